//--- project.f
+incdir+logic
+incdir+dv
logic/biu_pkg.sv
logic/cache_pkg.sv
logic/cache_ram.sv
logic/cache_setup.sv
logic/cache_lookup.sv
logic/cache_result.sv
logic/cache_top.sv
dv/cache_tb.sv

//--- Bender.yml
package:
  name: cache_lookup_pipeline

sources:
  - include_dirs:
      - logic
    files:
      - logic/biu_pkg.sv
      - logic/cache_pkg.sv
      - logic/cache_ram.sv
      - logic/cache_setup.sv
      - logic/cache_lookup.sv
      - logic/cache_result.sv
      - logic/cache_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cache_tb.sv

//--- dv/cache_model.svh
/*
  Behavioural cache model, included inside the testbench module
  Write-through, write-allocate on full-word write misses only
  Round-robin victim per set, pointers survive an invalidate
*/

`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

logic                       m_valid [`CACHE_SETS][`CACHE_WAYS];
logic [`CACHE_TAG_BITS-1:0] m_tag   [`CACHE_SETS][`CACHE_WAYS];
logic [`CACHE_XLEN-1:0]     m_data  [`CACHE_SETS][`CACHE_WAYS];
int                         m_ptr   [`CACHE_SETS];

// Clear valid bits, pointers only on reset
function automatic void model_clear(input bit with_ptr);
  for (int s = 0; s < `CACHE_SETS; s++)
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      m_valid[s][w] = 1'b0;
    end
    if (with_ptr)
    begin
      m_ptr[s] = 0;
    end
  end
endfunction

// One access, returns hit and read word, updates state for writes
function automatic void model_access(input logic we, input logic [1:0] size,
                                     input logic [31:0] adr, input logic [31:0] d,
                                     output logic hit, output logic [31:0] q);
  int                         set;
  int                         way;
  logic [`CACHE_TAG_BITS-1:0] tag;
  logic [3:0]                 be;
  set = adr[`CACHE_OFFS_BITS +: `CACHE_IDX_BITS];
  tag = adr[`CACHE_XLEN-1 -: `CACHE_TAG_BITS];
  hit = 1'b0;
  way = 0;
  for (int w = 0; w < `CACHE_WAYS; w++)
  begin
    if (m_valid[set][w] && m_tag[set][w] == tag)
    begin
      hit = 1'b1;
      way = w;
    end
  end
  q = hit ? m_data[set][way] : '0;
  if (we)
  begin
    // Byte lanes from size and offset
    case (size)
      2'd0:    be = 4'b0001 << adr[1:0];
      2'd1:    be = adr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
    if (hit)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
        begin
          m_data[set][way][8*b +: 8] = d[8*b +: 8];
        end
      end
    end
    else if (size == 2'd2)
    begin
      way = m_ptr[set];
      m_valid[set][way] = 1'b1;
      m_tag[set][way]   = tag;
      m_data[set][way]  = d;
      m_ptr[set]        = (m_ptr[set] + 1) % `CACHE_WAYS;
    end
  end
endfunction

`endif

//--- dv/cache_tb.sv
/*
  Testbench for the data-cache lookup pipeline
  Seeded random traffic over a 40-word address pool, checked in order
  against a behavioural model, each ack two pipeline moves after its accept
  Waits out the invalidate walk before new requests
*/

`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb
  import biu_pkg::*;
;

  `include "cache_model.svh"

  localparam int POOL    = 40;
  localparam int OPS     = 60 + 6 + 40 + 30 + 60 + 2 * POOL;
  localparam int WALK    = `CACHE_SETS + 8;
  localparam int LIMIT   = 2 * OPS + 4 * WALK + 7 * 31 + 200;
  localparam int ACK_LAT = 2;

  typedef struct packed {
    logic        we;
    logic [1:0]  size;
    logic [31:0] adr;
    logic [31:0] d;
    logic [2:0]  prot;
  } op_t;

  typedef struct packed {
    logic        we;
    logic        hit;
    logic [31:0] q;
    logic [31:0] adr;
    logic [31:0] d;
    logic [1:0]  size;
    logic [2:0]  prot;
    logic [31:0] mv;
  } exp_t;

  logic        clk_i;
  logic        rst_ni;
  logic        stall_i;
  logic        flush_i;
  logic        req_i;
  logic [31:0] adr_i;
  biu_size_t   size_i;
  biu_prot_t   prot_i;
  logic        we_i;
  logic [31:0] d_i;
  logic        invalidate_i;
  logic        ack_o;
  logic        hit_o;
  logic [31:0] q_o;
  logic        mem_we_o;
  logic [31:0] mem_adr_o;
  logic [31:0] mem_d_o;
  biu_size_t   mem_size_o;
  biu_prot_t   mem_prot_o;

  logic [31:0] pool [POOL];
  op_t         dir_q [$];
  exp_t        exp_q [$];
  exp_t        got;
  op_t         cur;
  bit          cur_stall;
  bit          cur_flush;
  logic        stall_seen;
  int          moves;
  int          errs;
  int          checks;
  int          flushed;
  int          cycles;
  int          e0;
  int          c0;

  cache_top dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .req_i        (req_i),
    .adr_i        (adr_i),
    .size_i       (size_i),
    .prot_i       (prot_i),
    .we_i         (we_i),
    .d_i          (d_i),
    .invalidate_i (invalidate_i),
    .ack_o        (ack_o),
    .hit_o        (hit_o),
    .q_o          (q_o),
    .mem_we_o     (mem_we_o),
    .mem_adr_o    (mem_adr_o),
    .mem_d_o      (mem_d_o),
    .mem_size_o   (mem_size_o),
    .mem_prot_o   (mem_prot_o)
  );

  ////////////////////
  // Clock, timeout
  ////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run length bounded by the op count and walk waits
  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("Run stopped, no finish after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // Checking
  ////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Stall level the DUT saw at the edge
  always @(posedge clk_i)
  begin
    stall_seen <= stall_i;
  end

  // Outputs settle after the rising edge, sample mid-cycle
  always @(negedge clk_i)
  begin
    // Edges at which the pipeline moved
    if (!stall_seen)
    begin
      moves++;
    end
    if (rst_ni)
    begin
      if (ack_o)
      begin
        if (exp_q.size() == 0)
        begin
          errs++;
          $display("Ack at %0t with no request outstanding", $time);
        end
        else
        begin
          got = exp_q.pop_front();
          compare_value("ack_o delay", ACK_LAT, moves - got.mv);
          compare_value("hit_o", got.hit, hit_o);
          if (!got.we)
          begin
            compare_value("q_o", got.q, q_o);
          end
          compare_value("mem_we_o", got.we, mem_we_o);
          if (got.we)
          begin
            compare_value("mem_adr_o", got.adr, mem_adr_o);
            compare_value("mem_d_o", got.d, mem_d_o);
            compare_value("mem_size_o", got.size, mem_size_o);
            compare_value("mem_prot_o", got.prot, mem_prot_o);
          end
        end
      end
      else if (mem_we_o)
      begin
        errs++;
        $display("Write-through at %0t without an ack", $time);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Directed ops first, then random from the pool
  function automatic op_t next_op(input int wr_pct, input bit partial);
    op_t op;
    if (dir_q.size() != 0)
    begin
      return dir_q.pop_front();
    end
    op.adr  = pool[$urandom_range(0, POOL - 1)];
    op.we   = ($urandom_range(0, 99) < wr_pct);
    op.size = (partial && op.we) ? 2'($urandom_range(0, 2)) : 2'd2;
    if (op.size == 2'd0)
    begin
      op.adr[1:0] = 2'($urandom_range(0, 3));
    end
    else if (op.size == 2'd1)
    begin
      op.adr[1] = 1'($urandom_range(0, 1));
    end
    op.d    = $urandom;
    op.prot = 3'($urandom_range(0, 7));
    return op;
  endfunction

  task automatic run_ops(input int n, input int stall_pct, input int flush_pct,
                         input int wr_pct, input bit partial);
    int          issued;
    bit          pending;
    logic        hit;
    logic [31:0] q;
    exp_t        e;
    issued  = 0;
    pending = 0;
    while (issued < n || pending)
    begin
      @(posedge clk_i);
      // Inputs driven last edge were just sampled
      if (pending && !cur_stall)
      begin
        pending = 0;
        if (cur_flush)
        begin
          flushed++;
        end
        else
        begin
          model_access(cur.we, cur.size, cur.adr, cur.d, hit, q);
          e.we   = cur.we;
          e.hit  = hit;
          e.q    = q;
          e.adr  = cur.adr;
          e.d    = cur.d;
          e.size = cur.size;
          e.prot = cur.prot;
          // Move count including this accepting edge
          e.mv   = moves + 1;
          exp_q.push_back(e);
        end
      end
      if (!pending && issued < n)
      begin
        cur = next_op(wr_pct, partial);
        issued++;
        pending = 1;
      end
      cur_stall = ($urandom_range(0, 99) < stall_pct);
      // Flush only while moving, a stalled flush would hit the held request
      cur_flush = pending && !cur_stall && ($urandom_range(0, 99) < flush_pct);
      req_i   <= pending;
      adr_i   <= cur.adr;
      we_i    <= cur.we;
      size_i  <= biu_size_t'(cur.size);
      prot_i  <= biu_prot_t'(cur.prot);
      d_i     <= cur.d;
      stall_i <= cur_stall;
      flush_i <= cur_flush;
    end
  endtask

  // Let all outstanding acks arrive
  task automatic drain();
    @(posedge clk_i);
    stall_i   <= 1'b0;
    flush_i   <= 1'b0;
    cur_stall = 0;
    cur_flush = 0;
    for (int i = 0; i < 30 && exp_q.size() != 0; i++)
    begin
      @(posedge clk_i);
    end
    if (exp_q.size() != 0)
    begin
      errs++;
      $display("%0d acks never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic do_invalidate();
    @(posedge clk_i);
    req_i        <= 1'b1;
    we_i         <= 1'b0;
    invalidate_i <= 1'b1;
    @(posedge clk_i);
    req_i        <= 1'b0;
    invalidate_i <= 1'b0;
    model_clear(0);
    repeat (WALK) @(posedge clk_i);
  endtask

  task automatic begin_test();
    e0 = errs;
    c0 = checks;
  endtask

  task automatic end_test(input string name);
    drain();
    $display("%s finished, %0d checks, %0d errors", name, checks - c0, errs - e0);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial
  begin
    void'($urandom(32'h6a0b_fb32));
    rst_ni       = 1'b0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    req_i        = 1'b0;
    adr_i        = '0;
    size_i       = WORD;
    prot_i       = '0;
    we_i         = 1'b0;
    d_i          = '0;
    invalidate_i = 1'b0;
    errs    = 0;
    checks  = 0;
    flushed = 0;
    cycles  = 0;
    moves   = 0;
    cur     = '0;
    // Pool index modulo 16 picks the set, sets 0 to 7 get three tags
    for (int i = 0; i < POOL; i++)
    begin
      pool[i] = 32'h2000_0000 | ((i / 16 * 37 + 5) << 6) | ((i % 16) << 2);
    end
    model_clear(1);
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Reset walk clears the tag RAM
    repeat (WALK) @(posedge clk_i);

    // Write then read the same word next cycle, read served by the bypass
    begin_test();
    for (int k = 0; k < 6; k++)
    begin
      cur.we   = ((k % 2) == 0);
      cur.size = 2'd2;
      cur.adr  = pool[5 + k / 2];
      cur.d    = $urandom;
      cur.prot = 3'd0;
      dir_q.push_back(cur);
    end
    run_ops(60, 0, 0, 50, 0);
    end_test("read after write");

    // Three tags of set 3, the first one gets evicted
    begin_test();
    do_invalidate();
    for (int k = 0; k < 6; k++)
    begin
      cur.we   = (k < 3);
      cur.size = 2'd2;
      cur.adr  = pool[3 + 16 * (k % 3)];
      cur.d    = $urandom;
      cur.prot = 3'd2;
      dir_q.push_back(cur);
    end
    run_ops(6, 0, 0, 0, 0);
    end_test("replacement");

    begin_test();
    run_ops(40, 0, 0, 60, 1);
    end_test("partial writes");

    begin_test();
    run_ops(30, 0, 0, 100, 1);
    end_test("write-through");

    begin_test();
    run_ops(60, 30, 10, 50, 1);
    end_test("stall and flush");
    $display("Requests dropped by flush: %0d", flushed);

    // Fill the pool, clear, then read everything back
    begin_test();
    run_ops(POOL, 0, 0, 100, 0);
    drain();
    do_invalidate();
    for (int i = 0; i < POOL; i++)
    begin
      cur      = '0;
      cur.size = 2'd2;
      cur.adr  = pool[i];
      dir_q.push_back(cur);
    end
    run_ops(POOL, 0, 0, 0, 0);
    end_test("invalidate");

    $display("Checks %0d, errors %0d, cycles %0d", checks, errs, cycles);
    if (errs == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- logic/cache_top.sv
/*
  Data-cache lookup pipeline, write-through and write-allocate
  ack_o follows an accepted request by 2 cycles plus any stall
  No refill, a read miss returns hit_o low and q_o zero
*/

`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top
  import biu_pkg::*, cache_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   stall_i,
  input  logic                   flush_i,
  input  logic                   req_i,
  input  logic [`CACHE_XLEN-1:0] adr_i,
  input  biu_size_t              size_i,
  input  biu_prot_t              prot_i,
  input  logic                   we_i,
  input  logic [`CACHE_XLEN-1:0] d_i,
  input  logic                   invalidate_i,
  output logic                   ack_o,
  output logic                   hit_o,
  output logic [`CACHE_XLEN-1:0] q_o,
  output logic                   mem_we_o,
  output logic [`CACHE_XLEN-1:0] mem_adr_o,
  output logic [`CACHE_XLEN-1:0] mem_d_o,
  output biu_size_t              mem_size_o,
  output biu_prot_t              mem_prot_o
);

  // Setup to lookup
  logic                        s_req;
  logic                        s_we;
  biu_size_t                   s_size;
  biu_prot_t                   s_prot;
  logic [`CACHE_XLEN-1:0]      s_d;
  logic                        s_inv;
  cache_tag_t                  s_tag;
  logic [`CACHE_OFFS_BITS-1:0] s_offs;
  logic [`CACHE_IDX_BITS-1:0]  s_idx;

  // Lookup and RAMs
  logic                        tag_we;
  tag_set_t                    tag_wd;
  tag_set_t                    tag_rd;
  logic                        tag_clr;
  logic                        data_we;
  data_set_t                   data_wd;
  data_set_t                   data_rd;
  logic [`CACHE_IDX_BITS-1:0]  ram_idx;

  // Lookup to result
  logic                        l_done;
  logic                        l_hit;
  logic [`CACHE_XLEN-1:0]      l_rdata;
  logic                        l_wt;
  logic [`CACHE_XLEN-1:0]      l_wt_adr;
  logic [`CACHE_XLEN-1:0]      l_wt_d;
  biu_size_t                   l_wt_size;
  biu_prot_t                   l_wt_prot;

  ////////////////////
  // Stages
  ////////////////////

  cache_setup u_setup (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .req_i        (req_i),
    .adr_i        (adr_i),
    .size_i       (size_i),
    .prot_i       (prot_i),
    .we_i         (we_i),
    .d_i          (d_i),
    .invalidate_i (invalidate_i),
    .req_o        (s_req),
    .we_o         (s_we),
    .size_o       (s_size),
    .prot_o       (s_prot),
    .d_o          (s_d),
    .invalidate_o (s_inv),
    .tag_o        (s_tag),
    .offs_o       (s_offs),
    .idx_o        (s_idx)
  );

  cache_lookup u_lookup (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .req_i        (s_req),
    .we_i         (s_we),
    .size_i       (s_size),
    .prot_i       (s_prot),
    .d_i          (s_d),
    .invalidate_i (s_inv),
    .tag_i        (s_tag),
    .offs_i       (s_offs),
    .idx_i        (s_idx),
    .tag_rd_i     (tag_rd),
    .data_rd_i    (data_rd),
    .tag_we_o     (tag_we),
    .tag_wd_o     (tag_wd),
    .data_we_o    (data_we),
    .data_wd_o    (data_wd),
    .ram_idx_o    (ram_idx),
    .tag_clr_o    (tag_clr),
    .done_o       (l_done),
    .hit_o        (l_hit),
    .rdata_o      (l_rdata),
    .wt_o         (l_wt),
    .wt_adr_o     (l_wt_adr),
    .wt_d_o       (l_wt_d),
    .wt_size_o    (l_wt_size),
    .wt_prot_o    (l_wt_prot)
  );

  cache_result u_result (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stall_i    (stall_i),
    .done_i     (l_done),
    .hit_i      (l_hit),
    .rdata_i    (l_rdata),
    .wt_i       (l_wt),
    .wt_adr_i   (l_wt_adr),
    .wt_d_i     (l_wt_d),
    .wt_size_i  (l_wt_size),
    .wt_prot_i  (l_wt_prot),
    .ack_o      (ack_o),
    .hit_o      (hit_o),
    .q_o        (q_o),
    .mem_we_o   (mem_we_o),
    .mem_adr_o  (mem_adr_o),
    .mem_d_o    (mem_d_o),
    .mem_size_o (mem_size_o),
    .mem_prot_o (mem_prot_o)
  );

  ////////////////////
  // Storage
  ////////////////////

  // Tag RAM, cleared set by set during the walk
  cache_ram #(
    .entry_t (tag_set_t),
    .DEPTH   (`CACHE_SETS)
  ) u_tag_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .idx_i  (ram_idx),
    .we_i   (tag_we),
    .wd_i   (tag_wd),
    .clr_i  (tag_clr),
    .rd_o   (tag_rd)
  );

  // Data RAM, contents only matter behind a valid tag
  cache_ram #(
    .entry_t (data_set_t),
    .DEPTH   (`CACHE_SETS)
  ) u_data_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .idx_i  (ram_idx),
    .we_i   (data_we),
    .wd_i   (data_wd),
    .clr_i  (1'b0),
    .rd_o   (data_rd)
  );

endmodule

//--- logic/cache_result.sv
/*
  Result stage, one register between lookup and the outside
  ack_o, hit_o and mem_we_o are single-cycle pulses
  q_o reads zero on a miss, payload holds while stalled
*/

`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_result
  import biu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   stall_i,
  input  logic                   done_i,
  input  logic                   hit_i,
  input  logic [`CACHE_XLEN-1:0] rdata_i,
  input  logic                   wt_i,
  input  logic [`CACHE_XLEN-1:0] wt_adr_i,
  input  logic [`CACHE_XLEN-1:0] wt_d_i,
  input  biu_size_t              wt_size_i,
  input  biu_prot_t              wt_prot_i,
  output logic                   ack_o,
  output logic                   hit_o,
  output logic [`CACHE_XLEN-1:0] q_o,
  output logic                   mem_we_o,
  output logic [`CACHE_XLEN-1:0] mem_adr_o,
  output logic [`CACHE_XLEN-1:0] mem_d_o,
  output biu_size_t              mem_size_o,
  output biu_prot_t              mem_prot_o
);

  ////////////////////
  // Strobes
  ////////////////////

  // Lookup holds its flags under stall, sample only when moving
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o    <= 1'b0;
      hit_o    <= 1'b0;
      mem_we_o <= 1'b0;
    end
    else
    begin
      ack_o    <= done_i & ~stall_i;
      hit_o    <= done_i & hit_i & ~stall_i;
      mem_we_o <= wt_i & ~stall_i;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      q_o        <= hit_i ? rdata_i : '0;
      mem_adr_o  <= wt_adr_i;
      mem_d_o    <= wt_d_i;
      mem_size_o <= wt_size_i;
      mem_prot_o <= wt_prot_i;
    end
  end

endmodule

//--- logic/cache_lookup.sv
/*
  Execute stage, tag compare and RAM update during the setup cycle
  After reset and after an invalidate the valid bits are cleared by a
  walk over all sets, CACHE_SETS unstalled cycles, and lookups miss meanwhile
  Write data sits on its byte lanes, partial write misses do not allocate
*/

`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_lookup
  import biu_pkg::*, cache_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        stall_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  biu_size_t                   size_i,
  input  biu_prot_t                   prot_i,
  input  logic [`CACHE_XLEN-1:0]      d_i,
  input  logic                        invalidate_i,
  input  cache_tag_t                  tag_i,
  input  logic [`CACHE_OFFS_BITS-1:0] offs_i,
  input  logic [`CACHE_IDX_BITS-1:0]  idx_i,
  input  tag_set_t                    tag_rd_i,
  input  data_set_t                   data_rd_i,
  output logic                        tag_we_o,
  output tag_set_t                    tag_wd_o,
  output logic                        data_we_o,
  output data_set_t                   data_wd_o,
  output logic [`CACHE_IDX_BITS-1:0]  ram_idx_o,
  output logic                        tag_clr_o,
  output logic                        done_o,
  output logic                        hit_o,
  output logic [`CACHE_XLEN-1:0]      rdata_o,
  output logic                        wt_o,
  output logic [`CACHE_XLEN-1:0]      wt_adr_o,
  output logic [`CACHE_XLEN-1:0]      wt_d_o,
  output biu_size_t                   wt_size_o,
  output biu_prot_t                   wt_prot_o
);

  localparam int NB = `CACHE_XLEN / 8;

  // Set of the request now in setup
  logic [`CACHE_IDX_BITS-1:0] req_idx;

  // Invalidate walk
  logic                       walk_active;
  logic [`CACHE_IDX_BITS-1:0] walk_cnt;
  logic                       rd_walk_q;
  logic                       blind;

  // Last-write bypass
  logic                       byp_valid;
  logic [`CACHE_IDX_BITS-1:0] byp_idx;
  tag_set_t                   byp_tags;
  data_set_t                  byp_words;
  logic                       byp_hit;

  // Set contents seen by the compare
  tag_set_t                   tags;
  data_set_t                  words;

  logic                       hit_any;
  way_t                       hit_way;
  way_t                       victim;
  way_t                       wr_way;
  way_t                       rr_ptr [`CACHE_SETS];

  logic                       acc;
  logic                       hit;
  logic                       wr_req;
  logic                       alloc;
  logic                       wr_en;
  logic [NB-1:0]              be;
  logic [`CACHE_XLEN-1:0]     new_word;

  ////////////////////
  // Index and walk
  ////////////////////

  // Walk owns the RAM index while active
  assign ram_idx_o = walk_active ? walk_cnt : idx_i;
  assign tag_clr_o = walk_active & ~stall_i;

  // Reset starts a walk so the tag RAM comes up invalid
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      walk_active <= 1'b1;
      walk_cnt    <= '0;
    end
    else if (!stall_i)
    begin
      if (walk_active)
      begin
        walk_cnt <= walk_cnt + 1'b1;
        // Counter wraps to zero on the last set
        if (&walk_cnt)
        begin
          walk_active <= 1'b0;
        end
      end
      else if (req_i && invalidate_i)
      begin
        walk_active <= 1'b1;
      end
    end
  end

  // RAMs re-register every edge, so does this flag
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_walk_q <= 1'b1;
    end
    else
    begin
      rd_walk_q <= walk_active;
    end
  end

  // Read word belongs to the walk, not to the request
  assign blind = walk_active | rd_walk_q;

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      req_idx <= idx_i;
    end
  end

  ////////////////////
  // Bypass
  ////////////////////

  // Previous edge wrote this set, RAM read data is stale
  assign byp_hit = byp_valid && (byp_idx == req_idx);
  assign tags    = byp_hit ? byp_tags  : tag_rd_i;
  assign words   = byp_hit ? byp_words : data_rd_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      byp_valid <= 1'b0;
    end
    else
    begin
      byp_valid <= wr_en;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      byp_idx   <= req_idx;
      byp_tags  <= tag_wd_o;
      byp_words <= data_wd_o;
    end
  end

  ////////////////////
  // Tag compare
  ////////////////////

  always_comb
  begin
    hit_any = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (tags[w].valid && (tags[w].tag == tag_i))
      begin
        hit_any = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Ordinary access, invalidate strobes excluded
  assign acc    = req_i & ~invalidate_i;
  assign hit    = acc & ~blind & hit_any;
  assign wr_req = acc & we_i;

  // Only a full word may allocate
  assign alloc  = wr_req & ~blind & ~hit_any & (size_i == WORD);
  assign wr_en  = ((wr_req & hit) | alloc) & ~stall_i;

  assign victim = rr_ptr[req_idx];
  assign wr_way = hit_any ? hit_way : victim;

  ////////////////////
  // Byte merge
  ////////////////////

  always_comb
  begin
    case (size_i)
      BYTE:    be = NB'(1) << offs_i;
      HWORD:   be = NB'(3) << {offs_i[`CACHE_OFFS_BITS-1], 1'b0};
      default: be = '1;
    endcase
  end

  always_comb
  begin
    new_word = words[wr_way];
    for (int b = 0; b < NB; b++)
    begin
      if (be[b])
      begin
        new_word[8*b +: 8] = d_i[8*b +: 8];
      end
    end
    // Whole set is rewritten, other ways unchanged
    tag_wd_o          = tags;
    tag_wd_o[wr_way]  = tag_entry_t'{valid: 1'b1, tag: tag_i};
    data_wd_o         = words;
    data_wd_o[wr_way] = new_word;
  end

  assign tag_we_o  = wr_en;
  assign data_we_o = wr_en;

  ////////////////////
  // Replacement
  ////////////////////

  // Round-robin per set, advanced on allocation only
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int s = 0; s < `CACHE_SETS; s++)
      begin
        rr_ptr[s] <= '0;
      end
    end
    else if (alloc && !stall_i)
    begin
      rr_ptr[req_idx] <= way_t'(victim + 1'b1);
    end
  end

  ////////////////////
  // To result stage
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      done_o <= 1'b0;
      hit_o  <= 1'b0;
      wt_o   <= 1'b0;
    end
    else if (!stall_i)
    begin
      done_o <= acc;
      hit_o  <= hit;
      wt_o   <= wr_req;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      rdata_o   <= words[hit_way];
      wt_adr_o  <= {tag_i, req_idx, offs_i};
      wt_d_o    <= d_i;
      wt_size_o <= size_i;
      wt_prot_o <= prot_i;
    end
  end

endmodule

//--- logic/cache_setup.sv
/*
  Decode stage
  flush_i at an edge drops the request registered at that edge
  Set index is combinational from adr_i, held while stalled
  The master holds its request inputs stable during stall_i
*/

`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_setup
  import biu_pkg::*, cache_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        stall_i,
  input  logic                        flush_i,
  input  logic                        req_i,
  input  logic [`CACHE_XLEN-1:0]      adr_i,
  input  biu_size_t                   size_i,
  input  biu_prot_t                   prot_i,
  input  logic                        we_i,
  input  logic [`CACHE_XLEN-1:0]      d_i,
  input  logic                        invalidate_i,
  output logic                        req_o,
  output logic                        we_o,
  output biu_size_t                   size_o,
  output biu_prot_t                   prot_o,
  output logic [`CACHE_XLEN-1:0]      d_o,
  output logic                        invalidate_o,
  output cache_tag_t                  tag_o,
  output logic [`CACHE_OFFS_BITS-1:0] offs_o,
  output logic [`CACHE_IDX_BITS-1:0]  idx_o
);

  logic                       flush_dly;
  logic [`CACHE_IDX_BITS-1:0] adr_idx;
  logic [`CACHE_IDX_BITS-1:0] adr_idx_dly;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      flush_dly <= 1'b0;
    end
    else
    begin
      flush_dly <= flush_i;
    end
  end

  // Flush wins over stall
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_o <= 1'b0;
    end
    else if (flush_i)
    begin
      req_o <= 1'b0;
    end
    else if (!stall_i)
    begin
      req_o <= req_i;
    end
  end

  ////////////////////
  // Attributes
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      we_o         <= we_i;
      size_o       <= size_i;
      prot_o       <= prot_i;
      d_o          <= d_i;
      invalidate_o <= invalidate_i;
      // Tag and offset for the compare and the bus address
      tag_o        <= adr_i[`CACHE_XLEN-1 -: `CACHE_TAG_BITS];
      offs_o       <= adr_i[`CACHE_OFFS_BITS-1:0];
    end
  end

  ////////////////////
  // Set index
  ////////////////////

  assign adr_idx = adr_i[`CACHE_OFFS_BITS +: `CACHE_IDX_BITS];

  // After a flush the held index follows the new address
  always_ff @(posedge clk_i)
  begin
    if (!stall_i || flush_dly)
    begin
      adr_idx_dly <= adr_idx;
    end
  end

  // RAMs re-read the same set while stalled
  assign idx_o = (stall_i && !flush_dly) ? adr_idx_dly : adr_idx;

endmodule

//--- logic/cache_ram.sv
/*
  One-port synchronous RAM, one word per set
  Read index registered every edge, read data valid the next cycle
  A write lands at the index read on the previous edge
  A read at the write edge returns the old contents
*/

`timescale 1ns/1ps

module cache_ram #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [$clog2(DEPTH)-1:0] idx_i,
  input  logic                     we_i,
  input  entry_t                   wd_i,
  input  logic                     clr_i,
  output entry_t                   rd_o
);

  // Storage, no reset
  entry_t mem [DEPTH];

  // Set read on the previous edge, target of the next write
  logic [$clog2(DEPTH)-1:0] wr_idx;

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    wr_idx <= idx_i;
    if (we_i)
    begin
      mem[wr_idx] <= wd_i;
    end
    // Clear walks the live index
    else if (clr_i)
    begin
      mem[idx_i] <= '0;
    end
  end

  ////////////////////
  // Registered read
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_o <= '0;
    end
    else
    begin
      rd_o <= mem[idx_i];
    end
  end

endmodule

//--- logic/cache_pkg.sv
/*
  Cache storage types
  One RAM word holds a whole set, all ways side by side
  Sizes come from cache_defs.svh
*/

`include "cache_defs.svh"

package cache_pkg;

  ////////////////////
  // Tag storage
  ////////////////////

  // Upper address bits above index and offset
  typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;

  // One way, valid bit on top
  typedef struct packed {
    logic       valid;
    cache_tag_t tag;
  } tag_entry_t;

  // Tag RAM word
  typedef tag_entry_t [`CACHE_WAYS-1:0] tag_set_t;

  ////////////////////
  // Data storage
  ////////////////////

  // Data RAM word, one block per way
  typedef logic [`CACHE_WAYS-1:0][`CACHE_XLEN-1:0] data_set_t;

  // Selects a way within a set
  typedef logic [`CACHE_WAY_BITS-1:0] way_t;

endpackage

//--- logic/biu_pkg.sv
/*
  Bus-interface attribute types
  Shared by the pipeline stages and the write-through port
  Write data travels on its natural byte lanes
*/

package biu_pkg;

  ////////////////////
  // Transfer size
  ////////////////////

  // Encodings follow the bus convention, 3 is unused
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_t;

  ////////////////////
  // Protection
  ////////////////////

  // Passed unchanged to the write-through transfer
  typedef struct packed {
    logic secure;
    logic data;
    logic privileged;
  } biu_prot_t;

endpackage

//--- logic/cache_defs.svh
/*
  Cache geometry for the data-cache lookup pipeline
  One-word blocks, so a set holds one word per way
  CACHE_SETS must equal 2**CACHE_IDX_BITS and CACHE_WAYS 2**CACHE_WAY_BITS
*/

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Address and data width
`define CACHE_XLEN 32

// Associativity and set count
`define CACHE_WAYS 2
`define CACHE_SETS 16

// Address split, byte offset then set index then tag
`define CACHE_OFFS_BITS 2
`define CACHE_IDX_BITS 4
`define CACHE_TAG_BITS (`CACHE_XLEN - `CACHE_IDX_BITS - `CACHE_OFFS_BITS)

// Way index
`define CACHE_WAY_BITS 1

`endif
